//--- common/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// Clock cycles in one serial bit
`define UART_CLKS_PER_BIT 16

`define UART_GAP_BITS 4          // Idle bits between write frames

// Bit times allowed before the reply start bit
`define UART_RD_TIMEOUT_BITS 40

`endif

//--- common/uart_pkg.sv
package uart_pkg;

  localparam int DATA_BITS  = 8;
  localparam int ADDR_BITS  = 7;
  localparam int CMD_WIDTH  = 1 + ADDR_BITS + DATA_BITS;
  localparam int FRAME_BITS = DATA_BITS + 3;   // start, data, parity, stop
  localparam int CMD_WR_BIT = CMD_WIDTH - 1;

  // Write command view
  typedef struct packed {
    logic                 wr;
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] wdata;
  } cmd_wr_t;

  // Read command view, low byte unused
  typedef struct packed {
    logic                 wr;
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] unused;
  } cmd_rd_t;

  typedef union packed {
    cmd_wr_t w;
    cmd_rd_t r;
  } cmd_word_u;

endpackage

//--- uart_tx/uart_tx_frame.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_tx_frame
  import uart_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 tx_start,
  input  logic [DATA_BITS-1:0] tx_byte,
  output logic                 tx,
  output logic                 tx_busy
);

  localparam int CPB = `UART_CLKS_PER_BIT;
  localparam int CW  = $clog2(CPB);
  localparam int IW  = $clog2(FRAME_BITS);

  localparam logic [CW-1:0] CNT_LAST = CW'(CPB - 1);
  localparam logic [IW-1:0] IDX_LAST = IW'(FRAME_BITS - 1);

  logic [FRAME_BITS-1:1] frame_q;
  logic [CW-1:0]         cyc_cnt;
  logic [IW-1:0]         bit_idx;
  logic                  load;

  assign load = tx_start && !tx_busy;

  // Stop, even parity, data LSB first
  always_ff @(posedge clk)
  begin
    if (load)
      frame_q <= {1'b1, ^tx_byte, tx_byte};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx      <= 1'b1;
      tx_busy <= 1'b0;
      cyc_cnt <= '0;
      bit_idx <= '0;
    end
    else if (load)
    begin
      tx      <= 1'b0;            // Start bit
      tx_busy <= 1'b1;
      cyc_cnt <= '0;
      bit_idx <= '0;
    end
    else if (tx_busy)
    begin
      if (cyc_cnt == CNT_LAST)
      begin
        cyc_cnt <= '0;
        if (bit_idx == IDX_LAST)
        begin
          tx_busy <= 1'b0;        // End of stop bit
          tx      <= 1'b1;
        end
        else
        begin
          bit_idx <= bit_idx + 1'b1;
          tx      <= frame_q[bit_idx + 1'b1];
        end
      end
      else
        cyc_cnt <= cyc_cnt + 1'b1;
    end
  end

  // Line must idle high between frames
  a_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> tx);

endmodule

//--- uart_rx/uart_rx_frame.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_rx_frame
  import uart_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  output logic [DATA_BITS-1:0] rx_byte,
  output logic                 rx_done,
  output logic                 rx_err,
  output logic                 rx_active
);

  localparam int CPB = `UART_CLKS_PER_BIT;
  localparam int CW  = $clog2(CPB);
  localparam int IW  = $clog2(FRAME_BITS);

  localparam logic [CW-1:0] CNT_LAST = CW'(CPB - 1);
  localparam logic [CW-1:0] CNT_MID  = CW'(CPB / 2 - 1);
  localparam logic [IW-1:0] IDX_PAR  = IW'(DATA_BITS + 1);
  localparam logic [IW-1:0] IDX_STOP = IW'(FRAME_BITS - 1);

  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_prev;
  logic                 fall;
  logic                 mid;
  logic [CW-1:0]        cyc_cnt;
  logic [IW-1:0]        bit_idx;
  logic [DATA_BITS-1:0] data_q;
  logic                 par_q;
  logic                 par_ok;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall    = rx_prev && !rx_sync;
  assign mid     = rx_active && (cyc_cnt == CNT_MID);
  assign par_ok  = ~^{data_q, par_q};   // Even parity over data and parity bit
  assign rx_byte = data_q;

  // Data shifts in LSB first
  always_ff @(posedge clk)
  begin
    if (mid && bit_idx != '0 && bit_idx < IDX_PAR)
      data_q <= {rx_sync, data_q[DATA_BITS-1:1]};
    if (mid && bit_idx == IDX_PAR)
      par_q <= rx_sync;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_active <= 1'b0;
      rx_done   <= 1'b0;
      rx_err    <= 1'b0;
      cyc_cnt   <= '0;
      bit_idx   <= '0;
    end
    else
    begin
      rx_done <= 1'b0;
      rx_err  <= 1'b0;
      if (!rx_active)
      begin
        if (fall)
        begin
          rx_active <= 1'b1;
          cyc_cnt   <= '0;
          bit_idx   <= '0;
        end
      end
      else
      begin
        cyc_cnt <= (cyc_cnt == CNT_LAST) ? '0 : cyc_cnt + 1'b1;
        if (mid)
        begin
          if (bit_idx == '0 && rx_sync)
            rx_active <= 1'b0;            // False start, dropped
          else if (bit_idx == IDX_STOP)
          begin
            rx_active <= 1'b0;
            if (rx_sync && par_ok)
              rx_done <= 1'b1;
            else
              rx_err <= 1'b1;
          end
          else
            bit_idx <= bit_idx + 1'b1;
        end
      end
    end
  end

  a_one_outcome: assert property (@(posedge clk) disable iff (!rst_n) !(rx_done && rx_err));

endmodule

//--- source/uart_cmd_seq.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_cmd_seq
  import uart_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [CMD_WIDTH-1:0] cmd_in,
  input  logic                 cmd_vld,
  input  logic                 tx_busy,
  input  logic                 rx_done,
  input  logic [DATA_BITS-1:0] rx_byte,
  input  logic                 rx_err,
  input  logic                 rx_active,
  output logic                 tx_start,
  output logic [DATA_BITS-1:0] tx_byte,
  output logic                 cmd_rdy,
  output logic                 read_rdy,
  output logic [DATA_BITS-1:0] read_data,
  output logic                 rd_err
);

  localparam int CPB = `UART_CLKS_PER_BIT;
  localparam int CW  = $clog2(CPB);
  localparam int BW  = $clog2(`UART_RD_TIMEOUT_BITS + 1);

  localparam logic [CW-1:0] CNT_LAST = CW'(CPB - 1);
  localparam logic [CW-1:0] CNT_PRE  = CW'(2);   // Wait exit and data start cycles
  localparam logic [BW-1:0] GAP_LAST = BW'(`UART_GAP_BITS - 1);
  localparam logic [BW-1:0] TO_LAST  = BW'(`UART_RD_TIMEOUT_BITS - 1);

  localparam logic [3:0] S_IDLE      = 4'd0,
                         S_HDR       = 4'd1,
                         S_HDR_WAIT  = 4'd2,
                         S_GAP       = 4'd3,
                         S_DATA      = 4'd4,
                         S_DATA_WAIT = 4'd5,
                         S_RD_WAIT   = 4'd6,
                         S_RD_RECV   = 4'd7,
                         S_DONE      = 4'd8;

  logic [3:0]    state;
  logic [3:0]    state_nxt;
  cmd_word_u     cmd_q;
  logic [CW-1:0] clk_cnt;
  logic [BW-1:0] bit_cnt;
  logic          accept;
  logic          gap_end;
  logic          to_end;

  assign cmd_rdy  = (state == S_IDLE) || (state == S_DATA_WAIT && !tx_busy);
  assign accept   = cmd_vld && cmd_rdy;
  assign gap_end  = (bit_cnt == GAP_LAST) && (clk_cnt == CNT_LAST);
  assign to_end   = (bit_cnt == TO_LAST) && (clk_cnt == CNT_LAST);
  assign tx_start = (state == S_HDR) || (state == S_DATA);
  // Header is flag plus address in both views
  assign tx_byte  = (state == S_DATA) ? cmd_q.w.wdata : {cmd_q[CMD_WR_BIT], cmd_q.r.addr};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= S_IDLE;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      S_IDLE:      if (accept) state_nxt = S_HDR;
      S_HDR:       state_nxt = S_HDR_WAIT;
      S_HDR_WAIT:  if (!tx_busy) state_nxt = cmd_q.w.wr ? S_GAP : S_RD_WAIT;
      S_GAP:       if (gap_end) state_nxt = S_DATA;
      S_DATA:      state_nxt = S_DATA_WAIT;
      S_DATA_WAIT: if (!tx_busy) state_nxt = accept ? S_HDR : S_IDLE;
      S_RD_WAIT:
      begin
        if (rx_active)
          state_nxt = S_RD_RECV;
        else if (to_end)
          state_nxt = S_DONE;             // No reply
      end
      S_RD_RECV:
      begin
        if (rx_done || rx_err)
          state_nxt = S_DONE;
        else if (!rx_active)
          state_nxt = S_RD_WAIT;          // False start on rx
      end
      default:     state_nxt = S_IDLE;
    endcase
  end

  // Shared bit timer for write gap and read timeout
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      clk_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (state == S_GAP || state == S_RD_WAIT || state == S_RD_RECV)
    begin
      if (clk_cnt == CNT_LAST)
      begin
        clk_cnt <= '0;
        bit_cnt <= bit_cnt + 1'b1;
      end
      else
        clk_cnt <= clk_cnt + 1'b1;
    end
    else
    begin
      clk_cnt <= CNT_PRE;
      bit_cnt <= '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
    if (state == S_RD_RECV && rx_done)
      read_data <= rx_byte;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_rdy <= 1'b0;
      rd_err   <= 1'b0;
    end
    else
    begin
      read_rdy <= (state == S_RD_RECV) && rx_done;
      rd_err   <= ((state == S_RD_RECV) && rx_err) ||
                  ((state == S_RD_WAIT) && !rx_active && to_end);
    end
  end

  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy);
  a_one_result: assert property (@(posedge clk) disable iff (!rst_n) !(read_rdy && rd_err));

endmodule

//--- source/uart_cmd_bridge.sv
`timescale 1ns/10ps

module uart_cmd_bridge
  import uart_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [CMD_WIDTH-1:0] cmd_in,
  input  logic                 cmd_vld,
  input  logic                 rx,
  output logic                 tx,
  output logic                 cmd_rdy,
  output logic                 read_rdy,
  output logic [DATA_BITS-1:0] read_data,
  output logic                 rd_err
);

  logic                 tx_start;
  logic [DATA_BITS-1:0] tx_byte;
  logic                 tx_busy;
  logic [DATA_BITS-1:0] rx_byte;
  logic                 rx_done;
  logic                 rx_err;
  logic                 rx_active;

  uart_cmd_seq u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .tx_busy   (tx_busy),
    .rx_done   (rx_done),
    .rx_byte   (rx_byte),
    .rx_err    (rx_err),
    .rx_active (rx_active),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .rd_err    (rd_err)
  );

  uart_tx_frame u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  // Always listening, strobes used only during a read
  uart_rx_frame u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_byte   (rx_byte),
    .rx_done   (rx_done),
    .rx_err    (rx_err),
    .rx_active (rx_active)
  );

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;   // Released on a falling edge
  end

endmodule

//--- tests/tb_uart_cmd_bridge.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"

module tb_uart_cmd_bridge
  import uart_pkg::*;
;

  localparam int BIT_CYC    = `UART_CLKS_PER_BIT;
  localparam int FIXED_ROWS = 6;
  localparam int NUM_ROWS   = 10;
  localparam int QUIET_BITS = 14;   // Long enough for a stray frame to show up
  localparam int M_GOOD     = 0;
  localparam int M_BADPAR   = 1;
  localparam int M_NONE     = 2;

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        rx;
  logic        tx;
  logic        cmd_rdy;
  logic        read_rdy;
  logic [7:0]  read_data;
  logic        rd_err;

  // Stimulus table
  logic [15:0] t_cmd    [NUM_ROWS];
  int          t_mode   [NUM_ROWS];
  logic [7:0]  t_reply  [NUM_ROWS];
  int          t_frames [NUM_ROWS];
  logic [7:0]  t_rdata  [NUM_ROWS];
  int          t_err    [NUM_ROWS];

  logic [7:0]  tx_q[$];             // Decoded tx bytes
  logic [7:0]  last_rdata;
  int          frame_cnt = 0;
  int          rdy_cnt   = 0;
  int          err_cnt   = 0;
  int          errors    = 0;
  int          checks    = 0;
  bit          timed_out = 1'b0;
  int          n;

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  uart_cmd_bridge u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .rd_err    (rd_err)
  );

  task automatic check_equal(input string name, input logic [15:0] exp, input logic [15:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic note_timeout(input string what);
    $display("Timeout: %s", what);
    errors++;
    timed_out = 1'b1;
  endtask

  task automatic set_row(input int idx, input logic [15:0] cmd, input int mode,
                         input logic [7:0] reply, input int frames,
                         input logic [7:0] rdata, input int err);
    t_cmd[idx]    = cmd;
    t_mode[idx]   = mode;
    t_reply[idx]  = reply;
    t_frames[idx] = frames;
    t_rdata[idx]  = rdata;
    t_err[idx]    = err;
  endtask

  task automatic fill_table();
    logic [6:0] addr;
    logic [7:0] data;
    set_row(0, {1'b1, 7'h12, 8'hA5}, M_NONE,   8'h00, 2, 8'h00, 0);
    set_row(1, {1'b1, 7'h7F, 8'h00}, M_NONE,   8'h00, 2, 8'h00, 0);
    set_row(2, {1'b0, 7'h05, 8'h00}, M_GOOD,   8'h3C, 1, 8'h3C, 0);
    set_row(3, {1'b0, 7'h40, 8'hEE}, M_BADPAR, 8'h81, 1, 8'h00, 1);  // Low byte ignored
    set_row(4, {1'b0, 7'h22, 8'h11}, M_NONE,   8'h00, 1, 8'h00, 1);
    set_row(5, {1'b0, 7'h00, 8'h77}, M_GOOD,   8'hFF, 1, 8'hFF, 0);
    for (int i = FIXED_ROWS; i < NUM_ROWS; i++)
    begin
      addr = 7'($urandom);
      data = 8'($urandom);
      if (i < FIXED_ROWS + 2)
        set_row(i, {1'b1, addr, data}, M_NONE, 8'h00, 2, 8'h00, 0);
      else if (i == FIXED_ROWS + 2)
        set_row(i, {1'b0, addr, 8'h00}, M_GOOD, data, 1, data, 0);
      else
        set_row(i, {1'b0, addr, 8'h00}, M_BADPAR, data, 1, 8'h00, 1);
    end
  endtask

  // Called on the first falling edge that sees the start bit
  task automatic decode_frame();
    logic [7:0] data;
    logic       par;
    logic       stop;
    data = '0;
    repeat (BIT_CYC / 2 - 1) @(negedge clk);
    check_equal("tx start bit", 16'h0, 16'(tx));
    for (int b = 0; b < 8; b++)
    begin
      repeat (BIT_CYC) @(negedge clk);
      data = {tx, data[7:1]};      // LSB first
    end
    repeat (BIT_CYC) @(negedge clk);
    par = tx;
    repeat (BIT_CYC) @(negedge clk);
    stop = tx;
    // Even number of ones over data and parity
    check_equal("tx even parity", 16'h0, 16'(^{data, par}));
    check_equal("tx stop bit", 16'h1, 16'(stop));
    tx_q.push_back(data);
    frame_cnt++;
  endtask

  task automatic send_reply(input logic [7:0] data, input logic bad_par);
    logic [10:0] bits;
    bits = {1'b1, (^data) ^ bad_par, data, 1'b0};
    for (int b = 0; b < 11; b++)
    begin
      rx = bits[0];
      bits = bits >> 1;
      repeat (BIT_CYC) @(negedge clk);
    end
    rx = 1'b1;
  endtask

  task automatic wait_ready(input int limit);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (cmd_rdy !== 1'b1 && cnt < limit)
    begin
      @(negedge clk);
      cnt++;
    end
    if (cmd_rdy !== 1'b1)
      note_timeout($sformatf("cmd_rdy stayed low for %0d cycles", limit));
  endtask

  task automatic wait_frames(input int count, input int limit);
    int cnt;
    cnt = 0;
    while (frame_cnt < count && cnt < limit)
    begin
      @(posedge clk);
      cnt++;
    end
    if (frame_cnt < count)
      note_timeout($sformatf("tx frame %0d did not arrive within %0d cycles", count, limit));
  endtask

  task automatic wait_result(input int count, input int limit);
    int cnt;
    cnt = 0;
    while (rdy_cnt + err_cnt < count && cnt < limit)
    begin
      @(posedge clk);
      cnt++;
    end
    if (rdy_cnt + err_cnt < count)
      note_timeout($sformatf("no read_rdy or rd_err within %0d bit times", limit / BIT_CYC));
  endtask

  task automatic run_row(input int i);
    logic [15:0] word;
    int          base_frames;
    int          base_rdy;
    int          base_err;
    int          exp_rdy;
    word = t_cmd[i];
    @(posedge clk);
    base_frames = frame_cnt;
    base_rdy    = rdy_cnt;
    base_err    = err_cnt;
    tx_q.delete();
    wait_ready(40 * BIT_CYC);
    if (timed_out)
      return;
    cmd_in  = word;
    cmd_vld = 1'b1;
    @(negedge clk);
    check_equal($sformatf("row %0d cmd_rdy after accept", i), 16'h0, 16'(cmd_rdy));
    cmd_in = ~word;                // Second strobe while busy
    @(negedge clk);
    cmd_vld = 1'b0;
    cmd_in  = '0;

    wait_frames(base_frames + 1, 25 * BIT_CYC);
    if (timed_out)
      return;
    check_equal($sformatf("row %0d header", i), 16'(word[15:8]), 16'(tx_q.pop_front()));
    if (word[CMD_WR_BIT])
    begin
      wait_frames(base_frames + 2, 20 * BIT_CYC);
      if (timed_out)
        return;
      check_equal($sformatf("row %0d wdata", i), 16'(word[7:0]), 16'(tx_q.pop_front()));
    end
    else
    begin
      if (t_mode[i] != M_NONE)
      begin
        @(negedge clk);
        repeat (3 * BIT_CYC) @(negedge clk);
        send_reply(t_reply[i], t_mode[i] == M_BADPAR);
      end
      wait_result(base_rdy + base_err + 1, 60 * BIT_CYC);
      if (timed_out)
        return;
    end
    wait_ready(4 * BIT_CYC);
    if (timed_out)
      return;

    repeat (QUIET_BITS * BIT_CYC) @(negedge clk);
    @(posedge clk);
    exp_rdy = (!word[CMD_WR_BIT] && t_err[i] == 0) ? 1 : 0;
    check_equal($sformatf("row %0d frames", i), 16'(t_frames[i]), 16'(frame_cnt - base_frames));
    check_equal($sformatf("row %0d read_rdy count", i), 16'(exp_rdy), 16'(rdy_cnt - base_rdy));
    check_equal($sformatf("row %0d rd_err count", i), 16'(t_err[i]), 16'(err_cnt - base_err));
    if (exp_rdy == 1)
      check_equal($sformatf("row %0d read_data", i), 16'(t_rdata[i]), 16'(last_rdata));
  endtask

  // Serial line monitor on tx
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (rst_n === 1'b1 && tx === 1'b0)
        decode_frame();
    end
  end

  // Strobe counters
  always @(negedge clk)
  begin
    if (read_rdy === 1'b1)
    begin
      rdy_cnt++;
      last_rdata = read_data;
    end
    if (rd_err === 1'b1)
      err_cnt++;
  end

  initial
  begin
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    void'($urandom(82));
    fill_table();
    n = 0;
    while (rst_n !== 1'b1 && n < 100)
    begin
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1)
      note_timeout("reset was never released");
    else
    begin
      @(negedge clk);
      check_equal("reset tx", 16'h1, 16'(tx));
      check_equal("reset cmd_rdy", 16'h1, 16'(cmd_rdy));
      check_equal("reset read_rdy", 16'h0, 16'(read_rdy));
      check_equal("reset rd_err", 16'h0, 16'(rd_err));
      for (int i = 0; i < NUM_ROWS && !timed_out; i++)
        run_row(i);
    end
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

//--- sources.f
+incdir+common
common/uart_pkg.sv
uart_tx/uart_tx_frame.sv
uart_rx/uart_rx_frame.sv
source/uart_cmd_seq.sv
source/uart_cmd_bridge.sv
tests/tb_clk_gen.sv
tests/tb_uart_cmd_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the UART command bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --timescale 1ns/10ps -f sources.f \
  --top-module tb_uart_cmd_bridge -o tb_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log; echo "Simulation exited with an error"; exit 1; }

cat sim.log
grep -q "Test FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
echo "Simulation passed"
